// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = bp_processor_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/bp_cmd_link_if.sv
// ready-and command link with source and destination modports
`timescale 1ns/100ps

interface bp_cmd_link_if;

   import bp_io_pkg::*;

   logic                    v;
   logic [did_width_gp-1:0] did;
   bp_io_opcode_e           opcode;
   bp_cmd_payload_u         payload;
   logic                    ready_and;   // sink can take the flit this cycle

   modport src (
      output v, did, opcode, payload,
      input  ready_and
   );

   modport dst (
      input  v, did, opcode, payload,
      output ready_and
   );

endinterface

// File: common/bp_io_pkg.sv
// flit field widths, command opcodes, payload union and register selects for the I/O node
package bp_io_pkg;

   // ========================================
   // field widths
   // ========================================
   localparam int did_width_gp     = 4;
   localparam int data_width_gp    = 32;
   localparam int payload_width_gp = 40;

   typedef enum logic [1:0] {
      e_mem_rd = 2'b00,
      e_mem_wr = 2'b01,
      e_cfg_rd = 2'b10,
      e_cfg_wr = 2'b11
   } bp_io_opcode_e;

   // one payload word, read either as a memory access or as a register access
   // the opcode of the flit decides which view is meaningful
   typedef union packed {
      struct packed {
         logic [7:0]               addr;
         logic [data_width_gp-1:0] wdata;
      } mem;
      struct packed {
         logic [1:0]  reg_sel;
         logic [21:0] spare;   // ignored on write, zero on the wire by convention
         logic [15:0] value;
      } cfg;
   } bp_cmd_payload_u;

   // ========================================
   // flit layouts, did at the top
   // ========================================
   // command flit is {did, opcode, payload}
   localparam int cmd_flit_width_gp =
      did_width_gp + $bits(bp_io_opcode_e) + payload_width_gp;

   // response flit is {src did, opcode, data}
   localparam int resp_flit_width_gp =
      did_width_gp + $bits(bp_io_opcode_e) + data_width_gp;

   // register selects seen by configuration commands
   localparam logic [1:0] cfg_latency_gp = 2'd0;
   localparam logic [1:0] cfg_scratch_gp = 2'd1;

endpackage

// File: common/bp_resp_link_if.sv
// ready-and response link with source and destination modports
`timescale 1ns/100ps

interface bp_resp_link_if;

   import bp_io_pkg::*;

   logic                     v;
   logic [did_width_gp-1:0]  did;   // id of the responding node
   bp_io_opcode_e            opcode;
   logic [data_width_gp-1:0] data;
   logic                     ready_and;

   modport src (
      output v, did, opcode, data,
      input  ready_and
   );

   modport dst (
      input  v, did, opcode, data,
      output ready_and
   );

endinterface

// File: mem/bp_mem_array.sv
// word-addressed storage array with synchronous write and registered read
`timescale 1ns/100ps

module bp_mem_array
  #(parameter int mem_els_p = 64
   )
  (input                                         core_clk_i
   ,input                                        we_i
   ,input [$clog2(mem_els_p)-1:0]                addr_i
   ,input [bp_io_pkg::data_width_gp-1:0]         wdata_i
   ,output logic [bp_io_pkg::data_width_gp-1:0]  rdata_o
   );

   import bp_io_pkg::*;

   logic [data_width_gp-1:0] mem_r [mem_els_p];

   always_ff @(posedge core_clk_i) begin
      if (we_i)
         mem_r[addr_i] <= wdata_i;
   end

   // read-before-write, so a write cycle returns the old word
   always_ff @(posedge core_clk_i) begin
      rdata_o <= mem_r[addr_i];
   end

endmodule

// File: mem/bp_mem_ctrl_fsm.sv
// memory controller FSM with latency and scratch registers, timer and storage array
`timescale 1ns/100ps

module bp_mem_ctrl_fsm
  #(parameter int mem_els_p     = 64
   ,parameter int mem_latency_p = 3
   )
  (input                                  core_clk_i
   ,input                                 arst_n_i

   ,input [bp_io_pkg::did_width_gp-1:0]   my_did_i

   ,bp_cmd_link_if.dst                    cmd_i
   ,bp_resp_link_if.src                   resp_o
   );

   import bp_io_pkg::*;

   localparam int addr_width_lp = $clog2(mem_els_p);

   localparam logic [1:0] s_idle = 2'd0;
   localparam logic [1:0] s_wait = 2'd1;
   localparam logic [1:0] s_cfg  = 2'd2;
   localparam logic [1:0] s_resp = 2'd3;

   logic [1:0]               state_r;
   logic [3:0]               lat_r;
   logic [15:0]              scratch_r;
   bp_io_opcode_e            opcode_r;
   bp_cmd_payload_u          payload_r;
   logic [data_width_gp-1:0] data_r;

   logic                     take;
   logic                     is_mem;
   logic                     timer_done;
   logic [addr_width_lp-1:0] arr_addr;
   logic [data_width_gp-1:0] arr_rdata;
   logic [data_width_gp-1:0] cfg_rdata;
   logic [3:0]               lat_wr;

   // flits for another node are sunk here without a response
   assign take   = cmd_i.v & (state_r == s_idle) & (cmd_i.did == my_did_i);
   assign is_mem = (cmd_i.opcode == e_mem_rd) | (cmd_i.opcode == e_mem_wr);

   // array sees the live address while idle, the latched one afterwards
   assign arr_addr = (state_r == s_idle) ? cmd_i.payload.mem.addr[addr_width_lp-1:0]
                                         : payload_r.mem.addr[addr_width_lp-1:0];

   bp_mem_timer timer
     (.core_clk_i(core_clk_i)
      ,.arst_n_i(arst_n_i)
      ,.load_i(take & is_mem)
      ,.count_i(lat_r)
      ,.done_o(timer_done)
      );

   bp_mem_array
    #(.mem_els_p(mem_els_p))
    array
     (.core_clk_i(core_clk_i)
      ,.we_i(take & (cmd_i.opcode == e_mem_wr))
      ,.addr_i(arr_addr)
      ,.wdata_i(cmd_i.payload.mem.wdata)
      ,.rdata_o(arr_rdata)
      );

   // ========================================
   // configuration registers
   // ========================================
   always_comb begin
      case (payload_r.cfg.reg_sel)
         cfg_latency_gp: cfg_rdata = data_width_gp'(lat_r);
         cfg_scratch_gp: cfg_rdata = data_width_gp'(scratch_r);
         default:        cfg_rdata = '0;
      endcase
   end

   // a latency of zero would never finish, so it becomes one
   assign lat_wr = (payload_r.cfg.value[3:0] == 4'd0) ? 4'd1 : payload_r.cfg.value[3:0];

   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r   <= s_idle;
         lat_r     <= 4'(mem_latency_p);
         scratch_r <= '0;
      end else begin
         case (state_r)
            s_idle: if (take) state_r <= is_mem ? s_wait : s_cfg;
            s_wait: if (timer_done) state_r <= s_resp;
            s_cfg: begin
               state_r <= s_resp;
               if (opcode_r == e_cfg_wr && payload_r.cfg.reg_sel == cfg_latency_gp)
                  lat_r <= lat_wr;
               if (opcode_r == e_cfg_wr && payload_r.cfg.reg_sel == cfg_scratch_gp)
                  scratch_r <= payload_r.cfg.value;
            end
            s_resp: if (resp_o.ready_and) state_r <= s_idle;
            default: state_r <= s_idle;
         endcase
      end
   end

   always_ff @(posedge core_clk_i) begin
      if (take) begin
         opcode_r  <= cmd_i.opcode;
         payload_r <= cmd_i.payload;
      end
      if (state_r == s_wait && timer_done)
         data_r <= (opcode_r == e_mem_rd) ? arr_rdata : '0;   // writes answer with zero
      if (state_r == s_cfg)
         data_r <= (opcode_r == e_cfg_rd) ? cfg_rdata : '0;
   end

   assign cmd_i.ready_and = (state_r == s_idle);

   assign resp_o.v      = (state_r == s_resp);
   assign resp_o.did    = my_did_i;
   assign resp_o.opcode = opcode_r;
   assign resp_o.data   = data_r;

endmodule

// File: mem/bp_mem_timer.sv
// down-counter modelling the memory access latency
`timescale 1ns/100ps

module bp_mem_timer
  (input                core_clk_i
   ,input               arst_n_i
   ,input               load_i
   ,input [3:0]         count_i
   ,output logic        done_o
   );

   logic [3:0] cnt_r;

   // done is registered, so it shows up one cycle after the count hits one
   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_r  <= '0;
         done_o <= 1'b0;
      end else if (load_i) begin
         cnt_r  <= count_i;
         done_o <= 1'b0;
      end else begin
         done_o <= (cnt_r == 4'd1);
         if (cnt_r != 4'd0)
            cnt_r <= cnt_r - 4'd1;   // parks at zero until the next load
      end
   end

endmodule

// File: src.f
common/bp_io_pkg.sv
common/bp_cmd_link_if.sv
common/bp_resp_link_if.sv
mem/bp_mem_timer.sv
mem/bp_mem_array.sv
mem/bp_mem_ctrl_fsm.sv
src/bp_io_cmd_router.sv
src/bp_resp_arbiter.sv
src/bp_processor.sv
testbench/bp_processor_sva.sv
testbench/bp_processor_tb.sv

// File: src/bp_io_cmd_router.sv
// command router splitting I/O flits between the local memory complex and the bypass link
`timescale 1ns/100ps

module bp_io_cmd_router
  (input                                          io_cmd_v_i
   ,input [bp_io_pkg::cmd_flit_width_gp-1:0]      io_cmd_data_i
   ,output logic                                  io_cmd_ready_o

   ,input [bp_io_pkg::did_width_gp-1:0]           my_did_i

   ,bp_cmd_link_if.src                            mem_cmd_o

   ,output logic                                  bypass_cmd_v_o
   ,output logic [bp_io_pkg::cmd_flit_width_gp-1:0] bypass_cmd_data_o
   ,input                                         bypass_cmd_ready_i
   );

   import bp_io_pkg::*;

   localparam int opcode_width_lp = $bits(bp_io_opcode_e);

   logic [did_width_gp-1:0] flit_did;
   logic                    local_hit;

   assign flit_did  = io_cmd_data_i[cmd_flit_width_gp-1 -: did_width_gp];
   assign local_hit = (flit_did == my_did_i);

   // ========================================
   // local side, flit split into fields
   // ========================================
   assign mem_cmd_o.v       = io_cmd_v_i & local_hit;
   assign mem_cmd_o.did     = flit_did;
   assign mem_cmd_o.opcode  =
      bp_io_opcode_e'(io_cmd_data_i[payload_width_gp +: opcode_width_lp]);
   assign mem_cmd_o.payload = bp_cmd_payload_u'(io_cmd_data_i[payload_width_gp-1:0]);

   // foreign flits leave untouched
   assign bypass_cmd_v_o    = io_cmd_v_i & ~local_hit;
   assign bypass_cmd_data_o = io_cmd_data_i;

   // the source only sees the ready of the side its flit is going to
   assign io_cmd_ready_o = local_hit ? mem_cmd_o.ready_and : bypass_cmd_ready_i;

endmodule

// File: src/bp_processor.sv
// I/O node top level with command router, memory controller and response arbiter
`timescale 1ns/100ps

module bp_processor
  #(parameter int mem_els_p     = 64
   ,parameter int mem_latency_p = 3
   )
  (input                                              core_clk_i
   ,input                                             arst_n_i

   ,input [bp_io_pkg::did_width_gp-1:0]               my_did_i

   // ========================================
   // I/O links
   // ========================================
   ,input                                             io_cmd_v_i
   ,input [bp_io_pkg::cmd_flit_width_gp-1:0]          io_cmd_data_i
   ,output logic                                      io_cmd_ready_o

   ,output logic                                      io_resp_v_o
   ,output logic [bp_io_pkg::resp_flit_width_gp-1:0]  io_resp_data_o
   ,input                                             io_resp_ready_i

   // ========================================
   // bypass links
   // ========================================
   ,output logic                                      bypass_cmd_v_o
   ,output logic [bp_io_pkg::cmd_flit_width_gp-1:0]   bypass_cmd_data_o
   ,input                                             bypass_cmd_ready_i

   ,input                                             bypass_resp_v_i
   ,input [bp_io_pkg::resp_flit_width_gp-1:0]         bypass_resp_data_i
   ,output logic                                      bypass_resp_ready_o
   );

   bp_cmd_link_if  mem_cmd_link ();
   bp_resp_link_if mem_resp_link ();

   bp_io_cmd_router router
     (.io_cmd_v_i(io_cmd_v_i)
      ,.io_cmd_data_i(io_cmd_data_i)
      ,.io_cmd_ready_o(io_cmd_ready_o)

      ,.my_did_i(my_did_i)

      ,.mem_cmd_o(mem_cmd_link)

      ,.bypass_cmd_v_o(bypass_cmd_v_o)
      ,.bypass_cmd_data_o(bypass_cmd_data_o)
      ,.bypass_cmd_ready_i(bypass_cmd_ready_i)
      );

   bp_mem_ctrl_fsm
    #(.mem_els_p(mem_els_p)
      ,.mem_latency_p(mem_latency_p)
      )
    mc
     (.core_clk_i(core_clk_i)
      ,.arst_n_i(arst_n_i)
      ,.my_did_i(my_did_i)
      ,.cmd_i(mem_cmd_link)
      ,.resp_o(mem_resp_link)
      );

   bp_resp_arbiter arb
     (.core_clk_i(core_clk_i)
      ,.arst_n_i(arst_n_i)

      ,.mem_resp_i(mem_resp_link)

      ,.bypass_resp_v_i(bypass_resp_v_i)
      ,.bypass_resp_data_i(bypass_resp_data_i)
      ,.bypass_resp_ready_o(bypass_resp_ready_o)

      ,.io_resp_v_o(io_resp_v_o)
      ,.io_resp_data_o(io_resp_data_o)
      ,.io_resp_ready_i(io_resp_ready_i)
      );

endmodule

// File: src/bp_resp_arbiter.sv
// round-robin arbiter merging memory and bypass responses onto the I/O response link
`timescale 1ns/100ps

module bp_resp_arbiter
  (input                                            core_clk_i
   ,input                                           arst_n_i

   ,bp_resp_link_if.dst                             mem_resp_i

   ,input                                           bypass_resp_v_i
   ,input [bp_io_pkg::resp_flit_width_gp-1:0]       bypass_resp_data_i
   ,output logic                                    bypass_resp_ready_o

   ,output logic                                    io_resp_v_o
   ,output logic [bp_io_pkg::resp_flit_width_gp-1:0] io_resp_data_o
   ,input                                           io_resp_ready_i
   );

   import bp_io_pkg::*;

   logic                          last_r;       // 1 when bypass won the last transfer
   logic                          hold_r;
   logic                          hold_sel_r;
   logic                          sel;          // 1 picks the bypass input
   logic [resp_flit_width_gp-1:0] mem_flit;

   assign mem_flit = {mem_resp_i.did, mem_resp_i.opcode, mem_resp_i.data};

   // an offer that stalled keeps its grant, so the output never changes under it
   always_comb begin
      if (hold_r)
         sel = hold_sel_r;
      else if (mem_resp_i.v && bypass_resp_v_i)
         sel = ~last_r;
      else
         sel = bypass_resp_v_i;
   end

   assign io_resp_v_o    = sel ? bypass_resp_v_i : mem_resp_i.v;
   assign io_resp_data_o = sel ? bypass_resp_data_i : mem_flit;

   assign mem_resp_i.ready_and = io_resp_ready_i & ~sel;
   assign bypass_resp_ready_o  = io_resp_ready_i & sel;

   always_ff @(posedge core_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_r     <= 1'b1;
         hold_r     <= 1'b0;
         hold_sel_r <= 1'b0;
      end else begin
         hold_r     <= io_resp_v_o & ~io_resp_ready_i;
         hold_sel_r <= sel;
         if (io_resp_v_o && io_resp_ready_i)
            last_r <= sel;   // pointer only moves on a completed transfer
      end
   end

endmodule

// File: testbench/bp_processor_sva.sv
// link stability and reset assertions for the I/O node, bound to the top level
`timescale 1ns/100ps

module bp_processor_sva
  (input                                             core_clk_i
   ,input                                            arst_n_i
   ,input                                            io_resp_v_o
   ,input [bp_io_pkg::resp_flit_width_gp-1:0]        io_resp_data_o
   ,input                                            io_resp_ready_i
   ,input                                            bypass_cmd_v_o
   ,input                                            mem_resp_v_i
   );

   // a stalled response keeps its valid and its data
   assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
      io_resp_v_o && !io_resp_ready_i |=> io_resp_v_o && $stable(io_resp_data_o))
      else $error("io response changed while stalled");

   assert property (@(posedge core_clk_i)
      !arst_n_i |-> !io_resp_v_o && !bypass_cmd_v_o && !mem_resp_v_i)
      else $error("valid raised during reset");

   assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
      !$isunknown(io_resp_v_o))
      else $error("io response valid unknown");

endmodule

bind bp_processor bp_processor_sva i_bp_processor_sva
  (.core_clk_i(core_clk_i)
   ,.arst_n_i(arst_n_i)
   ,.io_resp_v_o(io_resp_v_o)
   ,.io_resp_data_o(io_resp_data_o)
   ,.io_resp_ready_i(io_resp_ready_i)
   ,.bypass_cmd_v_o(bypass_cmd_v_o)
   ,.mem_resp_v_i(mem_resp_link.v)
   );

// File: testbench/bp_processor_tb.sv
// testbench for the I/O node with clock, reset, LFSR, reference model and directed tests
`timescale 1ns/100ps

module bp_processor_tb;

   import bp_io_pkg::*;

   localparam int mem_els_lp     = 64;
   localparam int mem_latency_lp = 3;
   localparam int num_cmds_lp    = 40;
   // worst-case latency 16, response wait and back-pressure 20, plus reset and slack
   localparam int timeout_lp     = num_cmds_lp * (16 + 20) + 300;
   localparam logic [3:0] my_did_lp = 4'h5;

   logic                          core_clk_i = 1'b0;
   logic                          arst_n_i;
   logic                          io_cmd_v_i;
   logic [cmd_flit_width_gp-1:0]  io_cmd_data_i;
   logic                          io_cmd_ready_o;
   logic                          io_resp_v_o;
   logic [resp_flit_width_gp-1:0] io_resp_data_o;
   logic                          io_resp_ready_i;
   logic                          bypass_cmd_v_o;
   logic [cmd_flit_width_gp-1:0]  bypass_cmd_data_o;
   logic                          bypass_cmd_ready_i;
   logic                          bypass_resp_v_i;
   logic [resp_flit_width_gp-1:0] bypass_resp_data_i;
   logic                          bypass_resp_ready_o;

   logic [31:0] lfsr_q = 32'h196d_7b54;
   int          error_count = 0;
   int          cycle_count = 0;

   // reference model of the array and the two registers
   logic [31:0] model_mem [mem_els_lp];
   bit          model_valid [mem_els_lp];
   logic [3:0]  model_lat;
   logic [15:0] model_scratch;

   always #10 core_clk_i = ~core_clk_i;

   bp_processor
    #(.mem_els_p(mem_els_lp)
      ,.mem_latency_p(mem_latency_lp)
      )
    i_bp_processor
     (.core_clk_i(core_clk_i)
      ,.arst_n_i(arst_n_i)
      ,.my_did_i(my_did_lp)
      ,.io_cmd_v_i(io_cmd_v_i)
      ,.io_cmd_data_i(io_cmd_data_i)
      ,.io_cmd_ready_o(io_cmd_ready_o)
      ,.io_resp_v_o(io_resp_v_o)
      ,.io_resp_data_o(io_resp_data_o)
      ,.io_resp_ready_i(io_resp_ready_i)
      ,.bypass_cmd_v_o(bypass_cmd_v_o)
      ,.bypass_cmd_data_o(bypass_cmd_data_o)
      ,.bypass_cmd_ready_i(bypass_cmd_ready_i)
      ,.bypass_resp_v_i(bypass_resp_v_i)
      ,.bypass_resp_data_i(bypass_resp_data_i)
      ,.bypass_resp_ready_o(bypass_resp_ready_o)
      );

   always @(posedge core_clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_lp) begin
         $display("Timeout: the tests did not finish within %0d cycles", timeout_lp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   // ========================================
   // helpers
   // ========================================
   task automatic take_bits(input int n, output logic [31:0] v);
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   task automatic send_cmd(input logic [cmd_flit_width_gp-1:0] flit);
      @(posedge core_clk_i);
      io_cmd_v_i    <= 1'b1;
      io_cmd_data_i <= flit;
      do @(negedge core_clk_i); while (!io_cmd_ready_o);
      @(posedge core_clk_i);
      io_cmd_v_i <= 1'b0;
   endtask

   // counts falling edges from the accept edge until the response shows up
   task automatic recv_resp(output logic [resp_flit_width_gp-1:0] flit, output int cycles);
      cycles = 0;
      do begin
         @(negedge core_clk_i);
         cycles++;
      end while (!io_resp_v_o);
      flit = io_resp_data_o;
      @(posedge core_clk_i);
   endtask

   function automatic logic [31:0] model_apply(input bp_io_opcode_e op, input logic [39:0] pl);
      int idx;
      idx = pl[39:32] % mem_els_lp;
      case (op)
         e_mem_wr: begin
            model_mem[idx]   = pl[31:0];
            model_valid[idx] = 1'b1;
            return '0;
         end
         e_mem_rd: return model_mem[idx];
         e_cfg_wr: begin
            if (pl[39:38] == cfg_latency_gp)
               model_lat = (pl[3:0] == 4'd0) ? 4'd1 : pl[3:0];
            if (pl[39:38] == cfg_scratch_gp)
               model_scratch = pl[15:0];
            return '0;
         end
         default: return (pl[39:38] == cfg_latency_gp) ? {28'd0, model_lat}
                                                       : {16'd0, model_scratch};
      endcase
   endfunction

   task automatic run_local(input bp_io_opcode_e op, input logic [39:0] pl);
      logic [resp_flit_width_gp-1:0] resp;
      logic [31:0]                   exp;
      int                            cycles;
      int                            lat;
      lat = model_lat;
      exp = model_apply(op, pl);
      send_cmd({my_did_lp, op, pl});
      recv_resp(resp, cycles);
      check_value("io_resp did", resp[37:34], my_did_lp);
      check_value("io_resp opcode", resp[33:32], op);
      check_value("io_resp data", resp[31:0], exp);
      // v rises L+1 edges after the accept and is seen at the falling edge after that
      if (op == e_mem_rd || op == e_mem_wr)
         check_value("latency reached", cycles >= lat + 2, 1);
   endtask

   // ========================================
   // directed tests
   // ========================================
   task automatic test_mem_rw();
      run_local(e_mem_wr, {8'h12, 32'hdead_beef});
      run_local(e_mem_rd, {8'h12, 32'h0});
      run_local(e_mem_wr, {8'h52, 32'h0bad_f00d});   // aliases 0x12 with 64 words
      run_local(e_mem_rd, {8'h12, 32'h0});
   endtask

   task automatic test_latency();
      run_local(e_cfg_wr, {cfg_latency_gp, 22'd0, 16'h0007});
      run_local(e_cfg_rd, {cfg_latency_gp, 22'd0, 16'h0});
      run_local(e_mem_rd, {8'h12, 32'h0});
      run_local(e_cfg_wr, {cfg_latency_gp, 22'd0, 16'h00f0});
      run_local(e_cfg_rd, {cfg_latency_gp, 22'd0, 16'h0});
      run_local(e_mem_rd, {8'h12, 32'h0});
      run_local(e_cfg_wr, {cfg_latency_gp, 22'd0, 16'h0002});
   endtask

   task automatic test_scratch();
      run_local(e_cfg_rd, {cfg_scratch_gp, 22'd0, 16'h0});
      run_local(e_cfg_wr, {cfg_scratch_gp, 22'd0, 16'ha5c3});
      run_local(e_cfg_rd, {cfg_scratch_gp, 22'd0, 16'h0});
   endtask

   task automatic test_bypass();
      logic [cmd_flit_width_gp-1:0]  cflit;
      logic [resp_flit_width_gp-1:0] rflit;
      cflit = {my_did_lp ^ 4'h3, e_mem_wr, 8'h44, 32'h1234_5678};
      rflit = {4'h9, e_mem_rd, 32'hcafe_0001};
      @(posedge core_clk_i);
      io_cmd_v_i         <= 1'b1;
      io_cmd_data_i      <= cflit;
      bypass_cmd_ready_i <= 1'b0;   // busy bypass sink while the memory side is idle
      @(negedge core_clk_i);
      check_value("bypass_cmd_v_o", bypass_cmd_v_o, 1);
      check_value("bypass_cmd_data_o", bypass_cmd_data_o, cflit);
      check_value("io_cmd_ready_o", io_cmd_ready_o, 0);
      @(posedge core_clk_i);
      bypass_cmd_ready_i <= 1'b1;
      @(negedge core_clk_i);
      check_value("bypass_cmd_data_o", bypass_cmd_data_o, cflit);
      check_value("io_cmd_ready_o", io_cmd_ready_o, 1);
      @(posedge core_clk_i);
      io_cmd_v_i         <= 1'b0;
      bypass_resp_v_i    <= 1'b1;
      bypass_resp_data_i <= rflit;
      @(negedge core_clk_i);
      check_value("io_resp_v_o", io_resp_v_o, 1);
      check_value("io_resp_data_o", io_resp_data_o, rflit);
      check_value("bypass_resp_ready_o", bypass_resp_ready_o, 1);
      @(posedge core_clk_i);
      bypass_resp_v_i <= 1'b0;
   endtask

   task automatic test_backpressure();
      logic [resp_flit_width_gp-1:0] held;
      logic [resp_flit_width_gp-1:0] resp;
      logic [31:0]                   hold;
      logic [31:0]                   exp1;
      logic [31:0]                   exp2;
      int                            cycles;
      run_local(e_mem_wr, {8'h03, 32'h3333_0003});
      exp1 = model_apply(e_mem_rd, {8'h12, 32'h0});
      exp2 = model_apply(e_mem_rd, {8'h03, 32'h0});
      io_resp_ready_i <= 1'b0;
      send_cmd({my_did_lp, e_mem_rd, 8'h12, 32'h0});
      @(posedge core_clk_i);
      io_cmd_v_i    <= 1'b1;   // second flit waits behind the stalled response
      io_cmd_data_i <= {my_did_lp, e_mem_rd, 8'h03, 32'h0};
      do begin
         @(negedge core_clk_i);
         check_value("io_cmd_ready_o", io_cmd_ready_o, 0);
      end while (!io_resp_v_o);
      held = io_resp_data_o;
      take_bits(4, hold);
      repeat (hold + 1) begin
         @(negedge core_clk_i);
         check_value("io_resp_v_o", io_resp_v_o, 1);
         check_value("io_resp_data_o", io_resp_data_o, held);
         check_value("io_cmd_ready_o", io_cmd_ready_o, 0);
      end
      @(posedge core_clk_i);
      io_resp_ready_i <= 1'b1;
      @(negedge core_clk_i);
      check_value("io_resp_data_o", io_resp_data_o, held);
      check_value("first resp data", held[31:0], exp1);
      @(posedge core_clk_i);
      @(negedge core_clk_i);
      check_value("io_resp_v_o", io_resp_v_o, 0);   // first response went out once
      check_value("io_cmd_ready_o", io_cmd_ready_o, 1);
      @(posedge core_clk_i);
      io_cmd_v_i <= 1'b0;
      recv_resp(resp, cycles);
      check_value("second resp data", resp[31:0], exp2);
   endtask

   task automatic test_random_mix();
      logic [31:0] r;
      logic [31:0] addr;
      logic [31:0] data;
      for (int i = 0; i < 16; i++) begin
         take_bits(3, r);
         take_bits(6, addr);
         take_bits(32, data);
         if (r[0]) begin
            @(posedge core_clk_i);
            io_cmd_v_i    <= 1'b1;
            io_cmd_data_i <= {my_did_lp ^ 4'h8, e_mem_rd, addr[7:0], data};
            @(negedge core_clk_i);
            check_value("bypass_cmd_v_o", bypass_cmd_v_o, 1);
            check_value("bypass_cmd_data_o", bypass_cmd_data_o,
                        {my_did_lp ^ 4'h8, e_mem_rd, addr[7:0], data});
            @(posedge core_clk_i);
            io_cmd_v_i <= 1'b0;
         end else if (r[2:1] == 2'd0 && model_valid[addr[5:0]])
            run_local(e_mem_rd, {addr[7:0], 32'h0});
         else if (r[2:1] == 2'd1)
            run_local(e_cfg_wr, {cfg_scratch_gp, 22'd0, data[15:0]});
         else if (r[2:1] == 2'd2)
            run_local(e_cfg_rd, {cfg_scratch_gp, 22'd0, 16'h0});
         else
            run_local(e_mem_wr, {addr[7:0], data});
      end
   endtask

   initial begin
      arst_n_i           = 1'b0;
      io_cmd_v_i         = 1'b0;
      io_cmd_data_i      = '0;
      io_resp_ready_i    = 1'b1;
      bypass_cmd_ready_i = 1'b1;
      bypass_resp_v_i    = 1'b0;
      bypass_resp_data_i = '0;
      model_lat          = 4'(mem_latency_lp);
      model_scratch      = '0;
      foreach (model_valid[i]) model_valid[i] = 1'b0;
      repeat (10) @(posedge core_clk_i);
      arst_n_i <= 1'b1;
      test_scratch();
      test_mem_rw();
      test_latency();
      test_bypass();
      test_backpressure();
      test_random_mix();
      repeat (3) @(posedge core_clk_i);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

endmodule
